/* Bender.yml */
package:
  name: rename_core

sources:
  - core_cfg_pkg.sv
  - isa_pkg.sv
  - issue_ctrl.sv
  - rob_ptr_counter.sv
  - rob_queue.sv
  - reg_rename_file.sv
  - rename_core.sv
  - target: test
    files:
      - tb_rename_core.sv

/* core_cfg_pkg.sv */
package core_cfg_pkg;

    // Datapath width
    localparam int xlen = 32;

    // Architectural register file
    localparam int reg_count  = 32;
    localparam int reg_name_w = $clog2(reg_count);

    // Reorder buffer geometry
    localparam int rob_depth = 8;
    localparam int rob_idx_w = $clog2(rob_depth);

    // Tag 0 means the value sits in the register file, so one extra bit
    localparam int tag_w = rob_idx_w + 1;

    // Occupancy has to hold 0 up to rob_depth inclusive
    localparam int count_w = rob_idx_w + 1;

    typedef logic [xlen-1:0]       data_t;
    typedef logic [reg_name_w-1:0] reg_name_t;
    typedef logic [tag_w-1:0]      tag_t;
    typedef logic [rob_idx_w-1:0]  rob_idx_t;
    typedef logic [count_w-1:0]    count_t;
    typedef logic [xlen-1:0]       pc_t;
    typedef logic [xlen-1:0]       imm_t;

    localparam count_t rob_full_count = count_t'(rob_depth);

    // Register x0 is hardwired to zero
    localparam reg_name_t reg_zero = '0;

    // No producer pending
    localparam tag_t tag_none = '0;

endpackage

/* isa_pkg.sv */
package isa_pkg;

    // Operation class as seen by rename
    localparam int op_w = 3;

    typedef logic [op_w-1:0] op_t;

    localparam op_t op_alu    = 3'd0;
    localparam op_t op_load   = 3'd1;
    localparam op_t op_store  = 3'd2;
    localparam op_t op_branch = 3'd3;
    localparam op_t op_jump   = 3'd4;

    localparam int op_count = 2 ** op_w;

    // Set for each op class that produces a register result
    // Stores and branches carry an rd field but write nothing
    localparam logic [op_count-1:0] op_writes_rd =
        (op_count'(1) << op_alu) |
        (op_count'(1) << op_load) |
        (op_count'(1) << op_jump);

endpackage

/* issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl
    import core_cfg_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   dec_valid,
    input  logic   flush,
    input  count_t count,
    input  logic   head_ready,
    output logic   accept,
    output logic   retire,
    output logic   clear,
    output logic   rob_full
);

    typedef enum logic [1:0] {
        st_run,
        st_full,
        st_flush
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_run: begin
                if (count == rob_full_count && !retire) begin
                    state_next = st_full;
                end
            end
            st_full: begin
                if (retire) begin
                    state_next = st_run; // A slot frees up at this edge
                end
            end
            st_flush: state_next = st_run;
            default:  state_next = st_run;
        endcase
        if (flush) begin
            state_next = st_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_run;
        end else begin
            state <= state_next;
        end
    end

    assign accept   = dec_valid && state == st_run && !flush;
    assign retire   = head_ready && state != st_flush;
    assign clear    = state == st_flush;
    assign rob_full = count == rob_full_count;

    // Decode has no ready, so it must hold off on its own
    a_no_dec_when_full: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> !rob_full);

endmodule

/* project.f */
core_cfg_pkg.sv
isa_pkg.sv
issue_ctrl.sv
rob_ptr_counter.sv
rob_queue.sv
reg_rename_file.sv
rename_core.sv
tb_rename_core.sv

/* reg_rename_file.sv */
`timescale 1ns/1ps

module reg_rename_file
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear,
    input  logic      accept,
    input  reg_name_t dec_rd,
    input  reg_name_t dec_rs1,
    input  reg_name_t dec_rs2,
    input  op_t       dec_op,
    input  pc_t       dec_pc,
    input  imm_t      dec_imm,
    input  logic      alloc,
    input  tag_t      alloc_tag,
    input  logic      retire,
    input  reg_name_t head_rd,
    input  data_t     head_data,
    input  tag_t      head_tag,
    output logic      disp_valid,
    output reg_name_t disp_rd,
    output tag_t      disp_tag,
    output op_t       disp_op,
    output pc_t       disp_pc,
    output imm_t      disp_imm,
    output data_t     disp_rs1_data,
    output tag_t      disp_rs1_tag,
    output data_t     disp_rs2_data,
    output tag_t      disp_rs2_tag,
    output logic      commit_valid,
    output reg_name_t commit_rd,
    output data_t     commit_data
);

    data_t reg_value [reg_count];
    tag_t  reg_tag   [reg_count];

    // True when the commit at this edge produces the value rs waits for
    function automatic logic commit_hits(input reg_name_t rs);
        return retire && reg_tag[rs] == head_tag;
    endfunction

    function automatic data_t operand_data(input reg_name_t rs);
        if (rs == reg_zero) begin
            return '0;
        end
        if (commit_hits(rs)) begin
            return head_data; // Same-edge bypass
        end
        return reg_value[rs];
    endfunction

    function automatic tag_t operand_tag(input reg_name_t rs);
        if (rs == reg_zero || commit_hits(rs)) begin
            return tag_none;
        end
        return reg_tag[rs];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                reg_value[i] <= '0;
                reg_tag[i]   <= tag_none;
            end
        end else begin
            if (retire) begin
                reg_value[head_rd] <= head_data;
            end
            if (clear) begin
                for (int i = 0; i < reg_count; i++) begin
                    reg_tag[i] <= tag_none; // Committed values stay
                end
            end else begin
                // A younger rename of the same register keeps its tag
                if (retire && reg_tag[head_rd] == head_tag &&
                    !(alloc && dec_rd == head_rd)) begin
                    reg_tag[head_rd] <= tag_none;
                end
                if (alloc) begin
                    reg_tag[dec_rd] <= alloc_tag;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_valid   <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            disp_valid   <= accept;
            commit_valid <= retire;
        end
    end

    // Operands are read before this instruction's own rename lands
    always_ff @(posedge clk) begin
        if (accept) begin
            disp_rd       <= dec_rd;
            disp_tag      <= alloc ? alloc_tag : tag_none;
            disp_op       <= dec_op;
            disp_pc       <= dec_pc;
            disp_imm      <= dec_imm;
            disp_rs1_data <= operand_data(dec_rs1);
            disp_rs1_tag  <= operand_tag(dec_rs1);
            disp_rs2_data <= operand_data(dec_rs2);
            disp_rs2_tag  <= operand_tag(dec_rs2);
        end
        if (retire) begin
            commit_rd   <= head_rd;
            commit_data <= head_data;
        end
    end

    // A retiring register is still renamed, by this entry or a younger one
    a_retire_renamed: assert property (@(posedge clk) disable iff (rst)
        retire |-> head_rd != reg_zero && reg_tag[head_rd] != tag_none);

endmodule

/* rename_core.sv */
`timescale 1ns/1ps

module rename_core
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dec_valid,
    input  reg_name_t dec_rd,
    input  reg_name_t dec_rs1,
    input  reg_name_t dec_rs2,
    input  op_t       dec_op,
    input  pc_t       dec_pc,
    input  imm_t      dec_imm,
    input  logic      wb_valid,
    input  tag_t      wb_tag,
    input  data_t     wb_data,
    input  logic      flush,
    output logic      disp_valid,
    output reg_name_t disp_rd,
    output tag_t      disp_tag,
    output op_t       disp_op,
    output pc_t       disp_pc,
    output imm_t      disp_imm,
    output data_t     disp_rs1_data,
    output tag_t      disp_rs1_tag,
    output data_t     disp_rs2_data,
    output tag_t      disp_rs2_tag,
    output logic      commit_valid,
    output reg_name_t commit_rd,
    output data_t     commit_data,
    output logic      rob_full
);

    logic      accept;
    logic      retire;
    logic      clear;
    logic      alloc;
    logic      head_ready;
    rob_idx_t  head;
    rob_idx_t  tail;
    count_t    count;
    tag_t      alloc_tag;
    tag_t      head_tag;
    reg_name_t head_rd;
    data_t     head_data;

    issue_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .dec_valid  (dec_valid),
        .flush      (flush),
        .count      (count),
        .head_ready (head_ready),
        .accept     (accept),
        .retire     (retire),
        .clear      (clear),
        .rob_full   (rob_full)
    );

    rob_ptr_counter u_ptr (
        .clk    (clk),
        .rst    (rst),
        .clear  (clear),
        .alloc  (alloc),
        .retire (retire),
        .head   (head),
        .tail   (tail),
        .count  (count)
    );

    rob_queue u_rob (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .accept     (accept),
        .dec_rd     (dec_rd),
        .dec_op     (dec_op),
        .head       (head),
        .tail       (tail),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .wb_data    (wb_data),
        .retire     (retire),
        .alloc      (alloc),
        .alloc_tag  (alloc_tag),
        .head_ready (head_ready),
        .head_rd    (head_rd),
        .head_data  (head_data),
        .head_tag   (head_tag)
    );

    reg_rename_file u_rf (
        .clk           (clk),
        .rst           (rst),
        .clear         (clear),
        .accept        (accept),
        .dec_rd        (dec_rd),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_op        (dec_op),
        .dec_pc        (dec_pc),
        .dec_imm       (dec_imm),
        .alloc         (alloc),
        .alloc_tag     (alloc_tag),
        .retire        (retire),
        .head_rd       (head_rd),
        .head_data     (head_data),
        .head_tag      (head_tag),
        .disp_valid    (disp_valid),
        .disp_rd       (disp_rd),
        .disp_tag      (disp_tag),
        .disp_op       (disp_op),
        .disp_pc       (disp_pc),
        .disp_imm      (disp_imm),
        .disp_rs1_data (disp_rs1_data),
        .disp_rs1_tag  (disp_rs1_tag),
        .disp_rs2_data (disp_rs2_data),
        .disp_rs2_tag  (disp_rs2_tag),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data)
    );

endmodule

/* rob_ptr_counter.sv */
`timescale 1ns/1ps

module rob_ptr_counter
    import core_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,
    input  logic     alloc,
    input  logic     retire,
    output rob_idx_t head,
    output rob_idx_t tail,
    output count_t   count
);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + rob_idx_t'(1); // Wraps modulo depth
            end
            if (retire) begin
                head <= head + rob_idx_t'(1);
            end
            case ({alloc, retire})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count; // None, or one in and one out
            endcase
        end
    end

    a_count_bounds: assert property (@(posedge clk) disable iff (rst)
        count <= rob_full_count &&
        !(retire && count == '0) &&
        !(alloc && !retire && count == rob_full_count));

endmodule

/* rob_queue.sv */
`timescale 1ns/1ps

module rob_queue
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      clear,
    input  logic      accept,
    input  reg_name_t dec_rd,
    input  op_t       dec_op,
    input  rob_idx_t  head,
    input  rob_idx_t  tail,
    input  logic      wb_valid,
    input  tag_t      wb_tag,
    input  data_t     wb_data,
    input  logic      retire,
    output logic      alloc,
    output tag_t      alloc_tag,
    output logic      head_ready,
    output reg_name_t head_rd,
    output data_t     head_data,
    output tag_t      head_tag
);

    logic      entry_valid [rob_depth];
    logic      entry_ready [rob_depth];
    reg_name_t entry_rd    [rob_depth];
    data_t     entry_data  [rob_depth];

    rob_idx_t wb_idx;

    // Only register-writing classes with a real destination take a slot
    assign alloc     = accept && op_writes_rd[dec_op] && dec_rd != reg_zero;
    assign alloc_tag = tag_t'(tail) + tag_t'(1);

    assign wb_idx = rob_idx_t'(wb_tag - tag_t'(1));

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int i = 0; i < rob_depth; i++) begin
                entry_valid[i] <= 1'b0;
                entry_ready[i] <= 1'b0;
            end
        end else begin
            if (wb_valid) begin
                entry_ready[wb_idx] <= 1'b1;
            end
            if (retire) begin
                entry_valid[head] <= 1'b0;
            end
            if (alloc) begin
                entry_valid[tail] <= 1'b1;
                entry_ready[tail] <= 1'b0;
            end
        end
    end

    // Destination and result of each entry
    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_rd[tail] <= dec_rd;
        end
        if (wb_valid) begin
            entry_data[wb_idx] <= wb_data;
        end
    end

    assign head_ready = entry_valid[head] && entry_ready[head];
    assign head_rd    = entry_rd[head];
    assign head_data  = entry_data[head];
    assign head_tag   = tag_t'(head) + tag_t'(1);

    // Execution answers only for in-flight work and only once per tag
    a_wb_tag_live: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_tag != tag_none && entry_valid[wb_idx] && !entry_ready[wb_idx]);

endmodule

/* tb_rename_core.sv */
`timescale 1ns/1ps

module tb_rename_core
    import core_cfg_pkg::*;
    import isa_pkg::*;
;

    localparam int phase_cycles = 500;
    localparam int cycle_limit  = 4000; // Five phases of 500 plus drain slack
    localparam int m_idle  = 0;
    localparam int m_zero  = 1;
    localparam int m_dep   = 2;
    localparam int m_store = 3;
    localparam int m_fill  = 4;
    localparam int m_flush = 5;

    logic      clk;
    logic      rst;
    logic      dec_valid;
    reg_name_t dec_rd;
    reg_name_t dec_rs1;
    reg_name_t dec_rs2;
    op_t       dec_op;
    pc_t       dec_pc;
    imm_t      dec_imm;
    logic      wb_valid;
    tag_t      wb_tag;
    data_t     wb_data;
    logic      flush;
    logic      disp_valid;
    reg_name_t disp_rd;
    tag_t      disp_tag;
    op_t       disp_op;
    pc_t       disp_pc;
    imm_t      disp_imm;
    data_t     disp_rs1_data;
    tag_t      disp_rs1_tag;
    data_t     disp_rs2_data;
    tag_t      disp_rs2_tag;
    logic      commit_valid;
    reg_name_t commit_rd;
    data_t     commit_data;
    logic      rob_full;

    // Shadow model of registers, tags and the in-flight entries
    data_t     sh_val [reg_count];
    tag_t      sh_tag [reg_count];
    tag_t      q_tag  [$];
    reg_name_t q_rd   [$];
    logic      q_rdy  [$];
    data_t     q_data [$];
    tag_t      pend_tag  [$];
    int        pend_wait [$];
    rob_idx_t  m_tail;
    logic      m_flush_st;

    logic      exp_disp_valid;
    reg_name_t exp_rd;
    tag_t      exp_tag;
    op_t       exp_op;
    pc_t       exp_pc;
    imm_t      exp_imm;
    data_t     exp_d1;
    tag_t      exp_t1;
    data_t     exp_d2;
    tag_t      exp_t2;
    logic      exp_commit_valid;
    reg_name_t exp_commit_rd;
    data_t     exp_commit_data;
    logic      exp_full;

    logic [31:0] lfsr = 32'h95d5;
    int          mode = m_idle;
    logic        released = 1'b0;
    int          errors = 0;
    int          tests_run = 0;
    int          cycles = 0;

    rename_core dut0 (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic reg_name_t pick_reg(input int m);
        if (m == m_zero) begin
            return reg_name_t'(rand_bits(2));
        end
        if (m == m_dep) begin
            return reg_name_t'(rand_bits(3)); // Few registers give many hazards
        end
        return reg_name_t'(rand_bits(5));
    endfunction

    task automatic note_failure(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic expect_operand(input reg_name_t rs, input logic ret,
                                  output data_t d, output tag_t t);
        if (rs == reg_zero) begin
            d = '0;
            t = tag_none;
        end else if (ret && sh_tag[rs] == q_tag[0]) begin
            d = q_data[0]; // Commit at the same edge
            t = tag_none;
        end else begin
            d = sh_val[rs];
            t = sh_tag[rs];
        end
    endtask

    always @(posedge clk) begin : model_and_drive
        logic m_retire;
        logic m_accept;
        logic m_alloc;
        int   pick;
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                sh_val[i] = '0;
                sh_tag[i] = tag_none;
            end
            q_tag.delete();
            q_rd.delete();
            q_rdy.delete();
            q_data.delete();
            pend_tag.delete();
            pend_wait.delete();
            m_tail = '0;
            m_flush_st = 1'b0;
            exp_disp_valid = 1'b0;
            exp_commit_valid = 1'b0;
            exp_full = 1'b0;
        end else begin
            m_retire = !m_flush_st && q_tag.size() > 0 && q_rdy[0];
            m_accept = dec_valid && !flush && !m_flush_st;
            m_alloc  = m_accept && dec_rd != reg_zero &&
                       (dec_op == op_alu || dec_op == op_load || dec_op == op_jump);
            exp_disp_valid = m_accept;
            if (m_accept) begin
                exp_rd  = dec_rd;
                exp_tag = m_alloc ? tag_t'(m_tail) + tag_t'(1) : tag_none;
                exp_op  = dec_op;
                exp_pc  = dec_pc;
                exp_imm = dec_imm;
                expect_operand(dec_rs1, m_retire, exp_d1, exp_t1);
                expect_operand(dec_rs2, m_retire, exp_d2, exp_t2);
            end
            exp_commit_valid = m_retire;
            if (m_retire) begin
                exp_commit_rd   = q_rd[0];
                exp_commit_data = q_data[0];
                sh_val[q_rd[0]] = q_data[0];
                if (sh_tag[q_rd[0]] == q_tag[0] && !(m_alloc && dec_rd == q_rd[0])) begin
                    sh_tag[q_rd[0]] = tag_none;
                end
                void'(q_tag.pop_front());
                void'(q_rd.pop_front());
                void'(q_rdy.pop_front());
                void'(q_data.pop_front());
            end
            if (wb_valid) begin
                foreach (q_tag[k]) begin
                    if (q_tag[k] == wb_tag) begin
                        q_rdy[k]  = 1'b1;
                        q_data[k] = wb_data;
                    end
                end
            end
            if (m_alloc) begin
                q_tag.push_back(exp_tag);
                q_rd.push_back(dec_rd);
                q_rdy.push_back(1'b0);
                q_data.push_back('0);
                sh_tag[dec_rd] = exp_tag;
                pend_tag.push_back(exp_tag);
                pend_wait.push_back(mode == m_fill ? 0 : int'(rand_bits(3)));
                m_tail = m_tail + rob_idx_t'(1);
            end
            if (m_flush_st) begin
                foreach (sh_tag[k]) sh_tag[k] = tag_none;
                q_tag.delete();
                q_rd.delete();
                q_rdy.delete();
                q_data.delete();
                m_tail = '0;
            end
            m_flush_st = flush;
            exp_full = q_tag.size() == rob_depth;

            // Execution stand-in gives at most one writeback per cycle
            pick = -1;
            foreach (pend_wait[k]) begin
                if (pend_wait[k] > 0) begin
                    pend_wait[k]--;
                end else if (pick < 0) begin
                    pick = k;
                end
            end
            if (mode == m_fill && exp_full) begin
                released <= 1'b1;
            end
            wb_valid <= 1'b0;
            if (pick >= 0 && (mode != m_fill || released)) begin
                wb_valid <= 1'b1;
                wb_tag   <= pend_tag[pick];
                wb_data  <= rand_bits(32);
                pend_tag.delete(pick);
                pend_wait.delete(pick);
            end
            flush <= 1'b0;
            if (mode == m_flush && rand_bits(5) == 0) begin
                flush <= 1'b1;
                pend_tag.delete();
                pend_wait.delete();
            end
            dec_valid <= 1'b0;
            if (mode != m_idle && !exp_full && (mode == m_fill || rand_bits(1))) begin
                dec_valid <= 1'b1;
                dec_rs1   <= pick_reg(mode);
                dec_rs2   <= pick_reg(mode);
                dec_pc    <= rand_bits(32);
                dec_imm   <= rand_bits(32);
                if (mode == m_fill) begin
                    dec_op <= op_alu;
                    dec_rd <= reg_name_t'(rand_bits(5)) | reg_name_t'(1);
                end else if (mode == m_store) begin
                    dec_op <= rand_bits(1) ? op_store : op_branch;
                    dec_rd <= pick_reg(mode);
                end else begin
                    dec_op <= op_t'(rand_bits(3) % 5);
                    dec_rd <= (mode == m_zero && rand_bits(1)) ? reg_zero : pick_reg(mode);
                end
            end
        end
    end

    a_disp_valid: assert property (@(posedge clk) disable iff (rst)
        disp_valid == exp_disp_valid) else note_failure("disp_valid mismatch");
    a_disp_fields: assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> disp_rd == exp_rd && disp_tag == exp_tag && disp_op == exp_op &&
                       disp_pc == exp_pc && disp_imm == exp_imm)
        else note_failure("dispatched fields differ");
    a_rs1: assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> disp_rs1_data == exp_d1 && disp_rs1_tag == exp_t1)
        else note_failure("rs1 operand wrong");
    a_rs2: assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> disp_rs2_data == exp_d2 && disp_rs2_tag == exp_t2)
        else note_failure("rs2 operand wrong");
    a_own_tag: assert property (@(posedge clk) disable iff (rst)
        disp_valid && disp_tag != tag_none |->
            disp_rs1_tag != disp_tag && disp_rs2_tag != disp_tag)
        else note_failure("operand carries its own new tag");
    a_no_rename: assert property (@(posedge clk) disable iff (rst)
        disp_valid && (disp_op == op_store || disp_op == op_branch) |-> disp_tag == tag_none)
        else note_failure("store or branch was renamed");
    a_commit: assert property (@(posedge clk) disable iff (rst)
        commit_valid == exp_commit_valid &&
        (!commit_valid || (commit_rd == exp_commit_rd && commit_data == exp_commit_data)))
        else note_failure("commit wrong or out of order");
    a_full: assert property (@(posedge clk) disable iff (rst)
        rob_full == exp_full) else note_failure("rob_full mismatch");

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Run stopped because the cycle limit was reached");
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic run_test(input string name, input int m);
        int errs_before;
        errs_before = errors;
        mode     <= m;
        released <= 1'b0;
        repeat (phase_cycles) @(posedge clk);
        mode <= m_idle;
        @(posedge clk);
        @(negedge clk);
        while (q_tag.size() > 0 || pend_tag.size() > 0) @(negedge clk);
        repeat (3) @(negedge clk);
        tests_run++;
        $display("test %-12s done, %0d checks failed", name, errors - errs_before);
    endtask

    initial begin
        rst       = 1'b1;
        dec_valid = 1'b0;
        dec_rd    = '0;
        dec_rs1   = '0;
        dec_rs2   = '0;
        dec_op    = op_alu;
        dec_pc    = '0;
        dec_imm   = '0;
        wb_valid  = 1'b0;
        wb_tag    = tag_none;
        wb_data   = '0;
        flush     = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        run_test("zero_reads", m_zero);
        run_test("dependency", m_dep);
        run_test("store_branch", m_store);
        run_test("fill", m_fill);
        run_test("flush", m_flush);
        $display("tests run %0d, checks failed %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
